// ==== compile.f ====
trig_pkg.sv
fifo_if.sv
readout_if.sv
sync_fifo.sv
trigger_processor.sv
readout_manager.sv
trigger_readout_top.sv
trigger_readout_chk.sv
tb_trigger_readout.sv

// ==== fifo_if.sv ====
// valid, ready and data interface between a FIFO and its reader
`timescale 1ns/1ns

interface fifo_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  // FIFO side presents the head entry
  modport source (output valid, output data, input ready);

  // reader acknowledges with ready while valid
  modport sink (input valid, input data, output ready);

endinterface

// ==== readout_if.sv ====
// handshake interface between trigger processor and readout manager
`timescale 1ns/1ns

interface readout_if ();
  import trig_pkg::*;

  // request side, pulses plus the latched trigger
  logic      initiate_readout;
  logic      send_empty_event;
  ttc_trig_t trig;

  // response side
  logic readout_ready;
  logic readout_done;

  modport req (
    output initiate_readout,
    output send_empty_event,
    output trig,
    input  readout_ready,
    input  readout_done
  );

  // trigger record reaches the manager on its own port
  modport rsp (
    input  initiate_readout,
    input  send_empty_event,
    output readout_ready,
    output readout_done
  );

endinterface

// ==== readout_manager.sv ====
// event record formatter that emits one 32-bit word per cycle and reports done
`timescale 1ns/1ns

module readout_manager (
  input  logic                 clk,
  input  logic                 reset,
  readout_if.rsp               rdo,
  input  trig_pkg::ttc_trig_t  trig,
  output logic                 evt_valid,
  output logic [31:0]          evt_data,
  output logic                 evt_last
);
  import trig_pkg::*;

  localparam int cnt_w = $clog2(evt_words);

  logic             busy;
  logic             empty_q;
  logic [cnt_w-1:0] word_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      empty_q  <= 1'b0;
      word_cnt <= '0;
    end else if (busy) begin
      if (evt_last) begin
        busy <= 1'b0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end else if (rdo.initiate_readout) begin
      // empty flag held for the whole event
      busy     <= 1'b1;
      empty_q  <= rdo.send_empty_event;
      word_cnt <= '0;
    end
  end

  assign evt_valid = busy;
  assign evt_last  = busy && (empty_q || word_cnt == cnt_w'(evt_words - 1));

  // word layout
  always_comb begin
    evt_data = '0;
    if (busy) begin
      case (word_cnt)
        cnt_w'(0): evt_data = {trig.empty_event, trig.trig_type, 5'b0, trig.event_num};
        cnt_w'(1): evt_data = {8'b0, trig.trig_num};
        cnt_w'(2): evt_data = trig.timestamp[31:0];
        default:   evt_data = {20'b0, trig.timestamp[43:32]};
      endcase
    end
  end

  assign rdo.readout_ready = !busy;
  assign rdo.readout_done  = evt_last;

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_trigger_readout -o sim \
  && ./obj_dir/sim | tee /dev/stderr | grep -qx "Test passed" \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

// ==== sync_fifo.sv ====
// show-ahead synchronous FIFO with full flag and parameterized payload type
`timescale 1ns/1ns

module sync_fifo #(
  parameter int  depth     = 8,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     wr,
  input  payload_t wr_data,
  output logic     full,
  fifo_if.source   rd
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // writes while full are dropped
  assign do_wr = wr && !full;
  assign do_rd = rd.valid && rd.ready;

  assign full     = (count == cnt_w'(depth));
  assign rd.valid = (count != '0);
  assign rd.data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

// ==== tb_trigger_readout.sv ====
// testbench for the trigger readout top level with reference model and event word compare
`timescale 1ns/1ns

module tb_trigger_readout;
  import trig_pkg::*;

  localparam int acq_depth = 8;
  localparam int trig_depth = 8;

  logic                  clk;
  logic                  reset;
  logic                  trig_wr;
  logic [127:0]          trig_wr_data;
  logic                  trig_full;
  logic                  acq_wr;
  logic [31:0]           acq_wr_data;
  logic                  acq_full;
  logic                  evt_valid;
  logic [31:0]           evt_data;
  logic                  evt_last;
  logic [num_states-1:0] state;
  logic                  error_trig_num;
  logic                  error_trig_type;

  integer       seed;
  int           data_errs;
  int           other_errs;
  int           k;
  string        test_name;
  logic [32:0]  exp_q[$];
  logic [32:0]  exp_w;
  logic [127:0] t;
  logic [127:0] t2;
  logic [127:0] trigs [acq_depth + 1];

  trigger_readout_top #(.trig_fifo_depth(trig_depth), .acq_fifo_depth(acq_depth))
    i_trigger_readout_top (
    .clk(clk), .reset(reset),
    .trig_wr(trig_wr), .trig_wr_data(trig_wr_data), .trig_full(trig_full),
    .acq_wr(acq_wr), .acq_wr_data(acq_wr_data), .acq_full(acq_full),
    .evt_valid(evt_valid), .evt_data(evt_data), .evt_last(evt_last),
    .state(state), .error_trig_num(error_trig_num), .error_trig_type(error_trig_type)
  );

  always #50 clk = !clk;

  // words of one event, last flag carried in bit 32
  function automatic void expected_words(input logic [127:0] tr);
    exp_q.push_back({tr[94], tr[94], tr[93:92], 5'b0, tr[91:68]});
    if (!tr[94]) begin
      exp_q.push_back({1'b0, 8'b0, tr[67:44]});
      exp_q.push_back({1'b0, tr[31:0]});
      exp_q.push_back({1'b1, 20'b0, tr[43:32]});
    end
  endfunction

  function automatic logic [127:0] random_trig(input logic empty);
    logic [127:0] r;
    r = {$random(seed), $random(seed), $random(seed), $random(seed)};
    r[127:95] = '0;
    r[94] = empty;
    return r;
  endfunction

  // acquisition record that matches a trigger
  function automatic logic [31:0] acq_for(input logic [127:0] tr);
    return {6'b0, tr[93:92], tr[67:44]};
  endfunction

  task automatic write_records(input logic do_trig, input logic [127:0] tr,
                               input logic do_acq, input logic [31:0] ac);
    @(posedge clk);
    #1;
    trig_wr      = do_trig;
    trig_wr_data = tr;
    acq_wr       = do_acq;
    acq_wr_data  = ac;
    @(posedge clk);
    #1;
    trig_wr = 1'b0;
    acq_wr  = 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    exp_q.delete();
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (exp_q.size() == 0) else begin
      other_errs++;
      $display("%s: timed out with %0d event words missing", test_name, exp_q.size());
    end
  endtask

  task automatic wait_error(input int limit);
    int n;
    n = 0;
    while (!error_trig_num && !error_trig_type && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (error_trig_num || error_trig_type) else begin
      other_errs++;
      $display("%s: no error flag raised within %0d cycles", test_name, limit);
    end
  endtask

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      data_errs++;
      $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  // compare each emitted word against the head of the queue
  always @(negedge clk) begin
    if (!reset && evt_valid) begin
      assert (exp_q.size() != 0) else begin
        other_errs++;
        $display("%s: event word %h arrived with none expected", test_name, evt_data);
      end
      if (exp_q.size() != 0) begin
        exp_w = exp_q.pop_front();
        assert (evt_data === exp_w[31:0] && evt_last === exp_w[32]) else begin
          data_errs++;
          $display("Fail %s: expected %h last %b, actual %h last %b",
                   test_name, exp_w[31:0], exp_w[32], evt_data, evt_last);
        end
      end
    end
  end

  initial begin
    seed         = 32'h6fcb4af4;
    data_errs    = 0;
    other_errs   = 0;
    clk          = 1'b0;
    reset        = 1'b1;
    trig_wr      = 1'b0;
    trig_wr_data = '0;
    acq_wr       = 1'b0;
    acq_wr_data  = '0;
    test_name    = "reset";
    apply_reset();

    test_name = "matching_pair";
    t = random_trig(1'b0);
    expected_words(t);
    write_records(1'b1, t, 1'b1, acq_for(t));
    wait_drain(100);

    // acquisition written with the empty trigger belongs to the next one
    test_name = "empty_event";
    t  = random_trig(1'b1);
    t2 = random_trig(1'b0);
    expected_words(t);
    expected_words(t2);
    write_records(1'b1, t, 1'b1, acq_for(t2));
    write_records(1'b1, t2, 1'b0, '0);
    wait_drain(100);

    test_name = "random_pairs";
    repeat (10) begin
      t = random_trig(1'b0);
      expected_words(t);
      write_records(1'b1, t, 1'b1, acq_for(t));
    end
    wait_drain(400);

    // one write past full is lost, so the last trigger finds no partner
    test_name = "acq_overflow";
    for (k = 0; k <= acq_depth; k++) begin
      trigs[k] = random_trig(1'b0);
      check_value({31'b0, k >= acq_depth}, {31'b0, acq_full});
      write_records(1'b0, '0, 1'b1, acq_for(trigs[k]));
    end
    for (k = 0; k <= acq_depth; k++) begin
      if (k < acq_depth) begin
        expected_words(trigs[k]);
      end
      write_records(1'b1, trigs[k], 1'b0, '0);
    end
    wait_drain(600);
    repeat (20) @(negedge clk);
    check_value(32'(1 << st_read_trig), 32'(state));

    test_name = "trig_num_mismatch";
    apply_reset();
    t = random_trig(1'b0);
    write_records(1'b1, t, 1'b1, acq_for(t) ^ 32'h1);
    wait_error(50);
    repeat (10) @(negedge clk);
    check_value(32'(1 << st_err_num), 32'(state));
    check_value(1, {31'b0, error_trig_num});
    check_value(0, {31'b0, error_trig_type});

    // FSM holds in the error state, so triggers pile up in their FIFO
    test_name = "trig_fifo_full";
    for (k = 0; k <= trig_depth; k++) begin
      check_value({31'b0, k >= trig_depth}, {31'b0, trig_full});
      if (k < trig_depth) begin
        write_records(1'b1, t, 1'b0, '0);
      end
    end

    // bit 24 is the low trig_type bit of the acquisition record
    test_name = "trig_type_mismatch";
    apply_reset();
    t = random_trig(1'b0);
    write_records(1'b1, t, 1'b1, acq_for(t) ^ 32'h0100_0000);
    wait_error(50);
    repeat (10) @(negedge clk);
    check_value(32'(1 << st_err_type), 32'(state));
    check_value(0, {31'b0, error_trig_num});
    check_value(1, {31'b0, error_trig_type});

    $display("errors: %0d value mismatches, %0d other failures", data_errs, other_errs);
    if (data_errs == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== trig_pkg.sv ====
// trigger and acquisition record layouts, one-hot state indices, event word count
package trig_pkg;

  // trigger record from the TTC trigger FIFO, 128 bits
  typedef struct packed {
    logic [32:0] reserved;
    logic        empty_event;
    logic [1:0]  trig_type;
    logic [23:0] event_num;
    logic [23:0] trig_num;
    logic [43:0] timestamp;
  } ttc_trig_t;

  // acquisition record, 32 bits
  typedef struct packed {
    logic [5:0]  reserved;
    logic [1:0]  trig_type;
    logic [23:0] trig_num;
  } acq_evt_t;

  // bit positions in the one-hot state vector
  localparam int st_idle       = 0;
  localparam int st_read_trig  = 1;
  localparam int st_send_empty = 2;
  localparam int st_read_acq   = 3;
  localparam int st_readout    = 4;
  localparam int st_err_num    = 5;
  localparam int st_err_type   = 6;

  localparam int num_states = 7;

  // words in a full event record
  localparam int evt_words = 4;

endpackage

// ==== trigger_processor.sv ====
// one-hot FSM that pairs trigger and acquisition records and starts readouts
`timescale 1ns/1ns

module trigger_processor (
  input  logic                            clk,
  input  logic                            reset,
  fifo_if.sink                            trig,
  fifo_if.sink                            acq,
  readout_if.req                          rdo,
  output logic [trig_pkg::num_states-1:0] state,
  output logic                            error_trig_num,
  output logic                            error_trig_type
);
  import trig_pkg::*;

  // latched trigger record
  ttc_trig_t trig_q;

  // latched acquisition fields
  logic [1:0]  acq_trig_type;
  logic [23:0] acq_trig_num;

  logic [num_states-1:0] next_state;
  ttc_trig_t             next_trig_q;
  logic [1:0]            next_acq_trig_type;
  logic [23:0]           next_acq_trig_num;

  always_comb begin
    next_state         = '0;
    next_trig_q        = trig_q;
    next_acq_trig_type = acq_trig_type;
    next_acq_trig_num  = acq_trig_num;

    trig.ready           = 1'b0;
    acq.ready            = 1'b0;
    rdo.initiate_readout = 1'b0;
    rdo.send_empty_event = 1'b0;

    case (1'b1)
      state[st_idle]: begin
        // take the next trigger when one is waiting
        if (trig.valid) begin
          next_trig_q              = trig.data;
          trig.ready               = 1'b1;
          next_state[st_read_trig] = 1'b1;
        end else begin
          next_state[st_idle] = 1'b1;
        end
      end
      state[st_read_trig]: begin
        if (trig_q.empty_event && rdo.readout_ready) begin
          // empty event needs no acquisition record
          rdo.initiate_readout      = 1'b1;
          rdo.send_empty_event      = 1'b1;
          next_state[st_send_empty] = 1'b1;
        end else if (!trig_q.empty_event && acq.valid) begin
          next_acq_trig_type      = acq.data.trig_type;
          next_acq_trig_num       = acq.data.trig_num;
          acq.ready               = 1'b1;
          next_state[st_read_acq] = 1'b1;
        end else begin
          next_state[st_read_trig] = 1'b1;
        end
      end
      state[st_send_empty]: begin
        if (rdo.readout_done) begin
          next_state[st_idle] = 1'b1;
        end else begin
          next_state[st_send_empty] = 1'b1;
        end
      end
      state[st_read_acq]: begin
        // number is checked before type
        if (trig_q.trig_num != acq_trig_num) begin
          next_state[st_err_num] = 1'b1;
        end else if (trig_q.trig_type != acq_trig_type) begin
          next_state[st_err_type] = 1'b1;
        end else if (rdo.readout_ready) begin
          rdo.initiate_readout   = 1'b1;
          next_state[st_readout] = 1'b1;
        end else begin
          next_state[st_read_acq] = 1'b1;
        end
      end
      state[st_readout]: begin
        if (rdo.readout_done) begin
          next_state[st_idle] = 1'b1;
        end else begin
          next_state[st_readout] = 1'b1;
        end
      end
      // sticky until reset
      state[st_err_num]: begin
        next_state[st_err_num] = 1'b1;
      end
      state[st_err_type]: begin
        next_state[st_err_type] = 1'b1;
      end
      default: begin
        next_state[st_idle] = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= '0;
      state[st_idle] <= 1'b1;
    end else begin
      state <= next_state;
    end
  end

  // record registers
  always_ff @(posedge clk) begin
    trig_q        <= next_trig_q;
    acq_trig_type <= next_acq_trig_type;
    acq_trig_num  <= next_acq_trig_num;
  end

  assign rdo.trig = trig_q;

  assign error_trig_num  = state[st_err_num];
  assign error_trig_type = state[st_err_type];

endmodule

// ==== trigger_readout_chk.sv ====
// concurrent assertions on FSM encoding, readout handshake and sticky error states
`timescale 1ns/1ns

module trigger_readout_chk (
  input logic                            clk,
  input logic                            reset,
  input logic [trig_pkg::num_states-1:0] state,
  input logic                            initiate_readout,
  input logic                            readout_ready,
  input logic                            readout_done,
  input logic                            evt_last
);
  import trig_pkg::*;

  state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state))
    else $error("FSM state vector is not one-hot");

  // manager must be idle when a readout starts and busy the cycle after
  initiate_when_ready: assert property (@(posedge clk) disable iff (reset)
    initiate_readout |-> readout_ready ##1 !readout_ready)
    else $error("initiate_readout issued while the manager is busy, or ignored");

  // done comes with the last word, then both sides are idle again
  done_with_last: assert property (@(posedge clk) disable iff (reset)
    readout_done |-> evt_last ##1 (readout_ready && state[st_idle]))
    else $error("readout_done not with evt_last or not followed by idle");

  err_num_sticky: assert property (@(posedge clk) disable iff (reset)
    state[st_err_num] |=> state[st_err_num])
    else $error("trigger number error state left without reset");

  err_type_sticky: assert property (@(posedge clk) disable iff (reset)
    state[st_err_type] |=> state[st_err_type])
    else $error("trigger type error state left without reset");

endmodule

// handshake signals taken from the processor to manager interface
bind trigger_readout_top trigger_readout_chk i_trigger_readout_chk (
  .clk(clk),
  .reset(reset),
  .state(state),
  .initiate_readout(rdo_if.initiate_readout),
  .readout_ready(rdo_if.readout_ready),
  .readout_done(rdo_if.readout_done),
  .evt_last(evt_last)
);

// ==== trigger_readout_top.sv ====
// top level with trigger and acquisition FIFOs, trigger processor and readout manager
`timescale 1ns/1ns

module trigger_readout_top #(
  parameter int trig_fifo_depth = 8,
  parameter int acq_fifo_depth  = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            trig_wr,
  input  trig_pkg::ttc_trig_t             trig_wr_data,
  output logic                            trig_full,
  input  logic                            acq_wr,
  input  trig_pkg::acq_evt_t              acq_wr_data,
  output logic                            acq_full,
  output logic                            evt_valid,
  output logic [31:0]                     evt_data,
  output logic                            evt_last,
  output logic [trig_pkg::num_states-1:0] state,
  output logic                            error_trig_num,
  output logic                            error_trig_type
);
  import trig_pkg::*;

  fifo_if #(.payload_t(ttc_trig_t)) trig_fifo_if ();
  fifo_if #(.payload_t(acq_evt_t))  acq_fifo_if ();
  readout_if                        rdo_if ();

  sync_fifo #(.depth(trig_fifo_depth), .payload_t(ttc_trig_t)) i_trig_fifo (
    .clk(clk), .reset(reset),
    .wr(trig_wr), .wr_data(trig_wr_data), .full(trig_full),
    .rd(trig_fifo_if.source)
  );

  sync_fifo #(.depth(acq_fifo_depth), .payload_t(acq_evt_t)) i_acq_fifo (
    .clk(clk), .reset(reset),
    .wr(acq_wr), .wr_data(acq_wr_data), .full(acq_full),
    .rd(acq_fifo_if.source)
  );

  trigger_processor i_trigger_processor (
    .clk(clk), .reset(reset),
    .trig(trig_fifo_if.sink), .acq(acq_fifo_if.sink), .rdo(rdo_if.req),
    .state(state), .error_trig_num(error_trig_num), .error_trig_type(error_trig_type)
  );

  // record travels from the processor latch to the formatter
  readout_manager i_readout_manager (
    .clk(clk), .reset(reset),
    .rdo(rdo_if.rsp), .trig(rdo_if.trig),
    .evt_valid(evt_valid), .evt_data(evt_data), .evt_last(evt_last)
  );

endmodule
